//--- Makefile
# Verilator flow for the peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_system
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
DEFINES   ?=
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(DEFINES) -f $(FILELIST) --top-module $(TOP)

# Build and run, exit status follows the testbench result
sim:
	$(VERILATOR) --binary $(VFLAGS) $(DEFINES) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- block_ram.sv
// Single-port block RAM
`timescale 1ns/1ps
`include "system_defines.svh"

module block_ram
   import bus_pkg::*;
(
   input  logic              clk,
   input  logic              cs,
   input  logic              we,
   input  logic [`RAM_AW-1:0] address,
   input  word_t             din,
   output word_t             dout
);

   // Word array, contents undefined until written
   word_t mem [0:`RAM_WORDS-1];

   // Write port
   always_ff @(posedge clk)
   begin
      if (cs && we)
      begin
         mem[address] <= din;
      end
   end

   // Registered read port
   // The word is held until the next selected read
   always_ff @(posedge clk)
   begin
      if (cs && !we)
      begin
         dout <= mem[address];
      end
   end

endmodule

//--- bus_decoder.sv
// Address decoder and read-data mux
`timescale 1ns/1ps
`include "system_defines.svh"

module bus_decoder
   import bus_pkg::*;
(
   input  logic  clk,
   input  logic  reset_b,
   input  addr_t address,
   input  logic  rnw,
   input  logic  vda,
   input  word_t ram_rdata,
   input  word_t uart_rdata,
   output logic  ram_cs,
   output logic  uart_cs,
   output logic  uart_reg,
   output word_t dout
);

   // Which target the previous cycle read from
   typedef enum logic [1:0]
   {
      SEL_NONE,
      SEL_RAM,
      SEL_UART
   } rd_sel_t;

   rd_sel_t rd_sel;
   logic    uart_hit;
   logic    ram_hit;

   // UART pair ignores address bit 0
   assign uart_hit = ({address[15:1], 1'b0} == `UART_BASE);

   // RAM aliased at bottom and top
   // Upper bits all 0 or all 1
   assign ram_hit = ~|address[15:`RAM_AW] || &address[15:`RAM_AW];

   // UART takes priority over the top RAM alias
   assign uart_cs  = vda && uart_hit;
   assign ram_cs   = vda && ram_hit && !uart_hit;
   assign uart_reg = address[0];

   // Remember the read target
   // Unmapped reads select none
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rd_sel <= SEL_NONE;
      end
      else if (vda && rnw)
      begin
         rd_sel <= uart_hit ? SEL_UART : (ram_hit ? SEL_RAM : SEL_NONE);
      end
      else
      begin
         rd_sel <= SEL_NONE;
      end
   end

   // Returned word
   always_comb
   begin
      case (rd_sel)
         SEL_RAM:  dout = ram_rdata;
         SEL_UART: dout = uart_rdata;
         default:  dout = '0;
      endcase
   end

   // Read with no target selected gives zero on the next cycle
   a_unmapped_zero: assert property (@(posedge clk) disable iff (!reset_b)
      (vda && rnw && !ram_cs && !uart_cs) |=> (dout == '0))
      else $error("bus_decoder: unmapped read returned nonzero data");

endmodule

//--- bus_pkg.sv
// Processor bus types
package bus_pkg;

   // Data bus width in bits
   localparam int WORD_W = 16;

   // Word address width, 64K words
   localparam int ADDR_W = 16;

   // One bus data word
   typedef logic [WORD_W-1:0] word_t;

   // One word address
   // No byte lanes, every address is a whole word
   typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- sim.f
+incdir+.
bus_pkg.sv
uart_pkg.sv
block_ram.sv
uart.sv
bus_decoder.sv
system.sv
tb_system.sv

//--- system.sv
// Peripheral subsystem top level
`timescale 1ns/1ps
`include "system_defines.svh"

module system
   import bus_pkg::*;
(
   input  logic  clk,
   input  logic  reset_b,
   input  addr_t address,
   input  word_t din,
   input  logic  rnw,
   input  logic  vda,
   output word_t dout,
   output logic  txd,
   input  logic  rxd
);

   logic  ram_cs;
   logic  uart_cs;
   logic  uart_reg;
   logic  we;
   word_t ram_rdata;
   word_t uart_rdata;

   // Write when rnw is low
   assign we = !rnw;

   bus_decoder u_decoder
   (
      .clk        (clk),
      .reset_b    (reset_b),
      .address    (address),
      .rnw        (rnw),
      .vda        (vda),
      .ram_rdata  (ram_rdata),
      .uart_rdata (uart_rdata),
      .ram_cs     (ram_cs),
      .uart_cs    (uart_cs),
      .uart_reg   (uart_reg),
      .dout       (dout)
   );

   // Low address bits only, so both aliases hit the same word
   block_ram u_ram
   (
      .clk     (clk),
      .cs      (ram_cs),
      .we      (we),
      .address (address[`RAM_AW-1:0]),
      .din     (din),
      .dout    (ram_rdata)
   );

   uart #(.CLKS_PER_BIT(`CLKS_PER_BIT)) u_uart
   (
      .clk     (clk),
      .reset_b (reset_b),
      .cs      (uart_cs),
      .we      (we),
      .reg_sel (uart_reg),
      .din     (din),
      .dout    (uart_rdata),
      .rxd     (rxd),
      .txd     (txd)
   );

endmodule

//--- system_defines.svh
// System memory map and timing constants
`ifndef SYSTEM_DEFINES_SVH
`define SYSTEM_DEFINES_SVH

// RAM address bits, 12 gives a 4096-word block RAM
`define RAM_AW 12

// Number of words in the RAM
`define RAM_WORDS (1 << `RAM_AW)

// UART register pair, status first and data next
`define UART_BASE 16'hfe08

// Status register, read only
`define UART_STAT_ADDR `UART_BASE

// Data register
// Writes start a frame, reads return the last byte received
`define UART_DATA_ADDR (`UART_BASE + 16'h0001)

// Baud divisor in clocks per serial bit
// Kept small so simulated frames stay short
`define CLKS_PER_BIT 16

`endif

//--- tb_system.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps
`include "system_defines.svh"

module tb_system
   import bus_pkg::*, uart_pkg::*;
();

   // Test sizes
   localparam int NUM_WORDS = 24;
   localparam int NUM_ALIAS = 8;
   localparam int NUM_BYTES = 4;

   // Run limit from bus accesses plus serial frames, doubled for margin
   localparam int ACCESS_CYCLES = 40 + 3 * NUM_WORDS + 4 * NUM_ALIAS + 24;
   localparam int FRAME_CYCLES = (NUM_BYTES + 1) * 10 * `CLKS_PER_BIT;
   localparam int CYCLE_LIMIT = 2 * (ACCESS_CYCLES + FRAME_CYCLES) + 200;

   logic  clk;
   logic  reset_b;
   addr_t address;
   word_t din;
   logic  rnw;
   logic  vda;
   word_t dout;
   logic  txd;
   logic  rxd;

   logic [31:0] lfsr;
   int          cycles = 0;

   // Reference RAM keyed by physical word index
   word_t ref_mem [int];

   // Expected read words in issue order, empty name means unchecked
   word_t exp_q [$];
   string name_q [$];

   system dut
   (
      .clk     (clk),
      .reset_b (reset_b),
      .address (address),
      .din     (din),
      .rnw     (rnw),
      .vda     (vda),
      .dout    (dout),
      .txd     (txd),
      .rxd     (rxd)
   );

   // Serial loopback
   assign rxd = txd;

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("test failed");
         $fatal(1, "Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic bit is_uart(addr_t a);
      return (a == `UART_STAT_ADDR) || (a == `UART_DATA_ADDR);
   endfunction

   // RAM answers when the upper bits are all zero or all one
   function automatic bit is_ram(addr_t a);
      addr_t upper;
      upper = a >> `RAM_AW;
      return !is_uart(a) && ((upper == 16'h0000) || (upper == (16'hffff >> `RAM_AW)));
   endfunction

   function automatic int ram_index(addr_t a);
      return int'(a) % `RAM_WORDS;
   endfunction

   // Same word seen from the top of the map
   function automatic addr_t top_alias(int idx);
      return addr_t'((16'hffff << `RAM_AW) | idx);
   endfunction

   // Expected read word, unmapped space reads zero
   function automatic word_t expected_read(addr_t a);
      if (is_ram(a) && ref_mem.exists(ram_index(a)))
      begin
         return ref_mem[ram_index(a)];
      end
      return 16'h0000;
   endfunction

   task automatic check(string name, word_t expected, word_t actual);
      if (actual !== expected)
      begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         $display("test failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic idle(int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // One write cycle, model follows the decode rules
   task automatic bus_write(addr_t a, word_t d);
      address = a;
      din = d;
      rnw = 1'b0;
      vda = 1'b1;
      if (is_ram(a))
      begin
         ref_mem[ram_index(a)] = d;
      end
      @(posedge clk);
      #1;
      vda = 1'b0;
      rnw = 1'b1;
   endtask

   // One read cycle, word is on dout right after the next edge
   task automatic bus_read(addr_t a, string name, word_t expected, output word_t got);
      exp_q.push_back(expected);
      name_q.push_back(name);
      address = a;
      rnw = 1'b1;
      vda = 1'b1;
      @(posedge clk);
      #1;
      vda = 1'b0;
      got = dout;
   endtask

   task automatic poll_status(int bit_pos, logic level);
      word_t got;
      do
      begin
         bus_read(`UART_STAT_ADDR, "", 16'h0000, got);
      end
      while (got[bit_pos] !== level);
   endtask

   // Compares each read word one cycle after its request
   initial
   begin : compare_reads
      word_t exp_word;
      string exp_name;
      forever
      begin
         @(posedge clk);
         if (vda && rnw)
         begin
            exp_word = exp_q.pop_front();
            exp_name = name_q.pop_front();
            @(negedge clk);
            if (exp_name != "")
            begin
               check(exp_name, exp_word, dout);
            end
         end
      end
   end

   initial
   begin : run_tests
      word_t got;
      word_t data;
      addr_t addrs [NUM_WORDS];
      addr_t unmapped [4] = '{16'h1000, 16'h7abc, 16'h8001, 16'hefff};
      byte_t tx_byte;
      int    idx;
      int    i;
      lfsr = 32'h2cc1;
      reset_b = 1'b0;
      address = '0;
      din = '0;
      rnw = 1'b1;
      vda = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset_b = 1'b1;
      idle(1);

      // State right after reset
      check("reset dout", 16'h0000, dout);
      check("reset txd", 16'h0001, {15'b0, txd});
      bus_read(`UART_STAT_ADDR, "reset status", 16'h0000, got);

      // Random low writes, then reads back to back
      for (i = 0; i < NUM_WORDS; i++)
      begin
         addrs[i] = addr_t'(rand_bits(`RAM_AW));
         bus_write(addrs[i], word_t'(rand_bits(16)));
      end
      for (i = 0; i < NUM_WORDS; i++)
      begin
         bus_read(addrs[i], "ram back to back read", expected_read(addrs[i]), got);
      end
      // A few isolated reads
      for (i = 0; i < 4; i++)
      begin
         bus_read(addrs[i], "ram single read", expected_read(addrs[i]), got);
         idle(2);
      end

      // Bottom and top aliases, both directions
      for (i = 0; i < NUM_ALIAS; i++)
      begin
         // Skip words hidden behind the UART pair
         do
         begin
            idx = int'(rand_bits(`RAM_AW));
         end
         while (is_uart(top_alias(idx)));
         data = word_t'(rand_bits(16));
         bus_write(addr_t'(idx), data);
         bus_read(top_alias(idx), "top alias read", data, got);
         bus_write(top_alias(idx), ~data);
         bus_read(addr_t'(idx), "low alias read", ~data, got);
      end

      // Unmapped space reads zero and leaves RAM alone
      for (i = 0; i < 4; i++)
      begin
         idx = ram_index(unmapped[i]);
         data = word_t'(rand_bits(16));
         bus_write(addr_t'(idx), data);
         bus_write(unmapped[i], ~data);
         bus_read(unmapped[i], "unmapped read", 16'h0000, got);
         bus_read(addr_t'(idx), "ram under unmapped write", data, got);
      end

      // Bytes through the loopback
      for (i = 0; i < NUM_BYTES; i++)
      begin
         tx_byte = byte_t'(rand_bits(8));
         poll_status(STAT_TX_BUSY, 1'b0);
         bus_write(`UART_DATA_ADDR, {8'h00, tx_byte});
         poll_status(STAT_RX_FULL, 1'b1);
         bus_read(`UART_DATA_ADDR, "uart rx data", {8'h00, tx_byte}, got);
         bus_read(`UART_STAT_ADDR, "", 16'h0000, got);
         check("uart rx_full clear", 16'h0000, {15'b0, got[STAT_RX_FULL]});
      end

      // UART pair wins over the top RAM alias
      idx = ram_index(`UART_STAT_ADDR);
      bus_write(addr_t'(idx), 16'h1234);
      bus_write(addr_t'(idx + 1), 16'h5678);
      poll_status(STAT_TX_BUSY, 1'b0);
      bus_write(`UART_STAT_ADDR, 16'hdead);
      bus_write(`UART_DATA_ADDR, 16'h00a5);
      bus_read(addr_t'(idx), "ram behind uart status", 16'h1234, got);
      bus_read(addr_t'(idx + 1), "ram behind uart data", 16'h5678, got);

      idle(4);
      if (exp_q.size() == 0)
      begin
         $display("test passed");
         $finish;
      end
      else
      begin
         $display("test failed");
         $fatal(1, "Read results still pending at the end of the run");
      end
   end

endmodule

//--- uart.sv
// Serial UART with status and data registers
`timescale 1ns/1ps
`include "system_defines.svh"

module uart
   import bus_pkg::*;
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = `CLKS_PER_BIT
)
(
   input  logic  clk,
   input  logic  reset_b,
   input  logic  cs,
   input  logic  we,
   input  logic  reg_sel,
   input  word_t din,
   output word_t dout,
   input  logic  rxd,
   output logic  txd
);

   // Baud counter width and wrap points
   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam int HALF = CLKS_PER_BIT / 2;
   localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] MID_LAST = CW'(HALF - 1);

   // Bus side strobes
   logic      wr_data;
   logic      rd_data;
   logic      rd_any;

   // Transmitter
   tx_state_t tx_state;
   logic [CW-1:0] tx_cnt;
   logic [2:0] tx_bit;
   byte_t     tx_shift;
   logic      tx_tick;
   logic      tx_busy;

   // Receiver
   rx_state_t rx_state;
   logic [CW-1:0] rx_cnt;
   logic [2:0] rx_bit;
   byte_t     rx_shift;
   byte_t     rx_data;
   logic      rx_full;
   logic [2:0] rx_pipe;
   logic      rx_s;
   logic      rx_fall;

   word_t     status;

   assign wr_data = cs && we && reg_sel;
   assign rd_data = cs && !we && reg_sel;
   assign rd_any  = cs && !we;

   assign tx_tick = (tx_cnt == BIT_LAST);
   assign tx_busy = (tx_state != TX_IDLE);

   // Transmit FSM
   // Start bit low, 8 data bits LSB first, stop bit high
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         tx_state <= TX_IDLE;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         txd      <= 1'b1;
      end
      else
      begin
         // Baud counter runs only inside a frame
         if (tx_busy)
         begin
            tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
         end
         case (tx_state)
            TX_IDLE:
            begin
               // Writes while busy fall through and are dropped
               if (wr_data)
               begin
                  tx_shift <= din[7:0];
                  tx_cnt   <= '0;
                  txd      <= 1'b0;
                  tx_state <= TX_START;
               end
            end
            TX_START:
            begin
               if (tx_tick)
               begin
                  txd      <= tx_shift[0];
                  tx_shift <= tx_shift >> 1;
                  tx_bit   <= '0;
                  tx_state <= TX_DATA;
               end
            end
            TX_DATA:
            begin
               if (tx_tick)
               begin
                  if (tx_bit == 3'd7)
                  begin
                     txd      <= 1'b1;
                     tx_state <= TX_STOP;
                  end
                  else
                  begin
                     txd      <= tx_shift[0];
                     tx_shift <= tx_shift >> 1;
                     tx_bit   <= tx_bit + 1'b1;
                  end
               end
            end
            default:
            begin
               // Busy drops at the end of the stop bit
               if (tx_tick)
               begin
                  tx_state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   // Two-flop synchronizer plus one for edge detect
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rx_pipe <= '1;
      end
      else
      begin
         rx_pipe <= {rx_pipe[1:0], rxd};
      end
   end

   assign rx_s    = rx_pipe[1];
   assign rx_fall = rx_pipe[2] && !rx_pipe[1];

   // Receive FSM, samples each bit at its middle
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_full  <= 1'b0;
      end
      else
      begin
         // Reading data empties the buffer, a new frame wins below
         if (rd_data)
         begin
            rx_full <= 1'b0;
         end
         case (rx_state)
            RX_IDLE:
            begin
               if (rx_fall)
               begin
                  rx_cnt   <= '0;
                  rx_state <= RX_START;
               end
            end
            RX_START:
            begin
               if (rx_cnt == MID_LAST)
               begin
                  // Glitch check at mid start bit
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  rx_state <= rx_s ? RX_IDLE : RX_DATA;
               end
               else
               begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            RX_DATA:
            begin
               if (rx_cnt == BIT_LAST)
               begin
                  rx_cnt   <= '0;
                  rx_shift <= {rx_s, rx_shift[7:1]};
                  rx_bit   <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7)
                  begin
                     rx_state <= RX_STOP;
                  end
               end
               else
               begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            default:
            begin
               if (rx_cnt == BIT_LAST)
               begin
                  // Framing error drops the byte
                  if (rx_s)
                  begin
                     rx_data <= rx_shift;
                     rx_full <= 1'b1;
                  end
                  rx_state <= RX_IDLE;
               end
               else
               begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   always_comb
   begin
      status = '0;
      status[STAT_TX_BUSY] = tx_busy;
      status[STAT_RX_FULL] = rx_full;
   end

   // Register read, one cycle latency
   always_ff @(posedge clk)
   begin
      if (rd_any)
      begin
         dout <= reg_sel ? {8'h00, rx_data} : status;
      end
   end

   // Line idles high
   a_txd_idle: assert property (@(posedge clk) disable iff (!reset_b)
      (tx_state == TX_IDLE) |-> txd)
      else $error("uart: txd low while transmitter idle");

   // Write during a frame must not restart it
   a_no_restart: assert property (@(posedge clk) disable iff (!reset_b)
      (wr_data && tx_busy) |=> !(tx_state == TX_START && tx_cnt == '0))
      else $error("uart: data write accepted while busy");

endmodule

//--- uart_pkg.sv
// UART types and status bits
package uart_pkg;

   // Payload of one serial frame
   typedef logic [7:0] byte_t;

   // Transmit FSM
   typedef enum logic [1:0]
   {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   // Receive FSM
   typedef enum logic [1:0]
   {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // Bit positions in the status word
   localparam int STAT_TX_BUSY = 0;
   localparam int STAT_RX_FULL = 1;

endpackage
